// File: cpu_pkg.sv
package cpu_pkg;

    // stores into this 16-byte window go out as a single byte
    localparam logic [31:0] IO_BASE = 32'h0003_0000;

    // RV32I major opcodes that the core knows
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_LUI,
        KIND_JAL,
        KIND_BEQ,
        KIND_BNE,
        KIND_LOAD,
        KIND_STORE,
        KIND_NOP
    } inst_kind_e;

    typedef enum logic {
        MEM_BYTE,
        MEM_WORD
    } mem_size_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    // sdata is the store data, or the pc offset for branches and jal
    typedef struct packed {
        logic        valid;
        inst_kind_e  kind;
        alu_op_e     alu_op;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] sdata;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;
        mem_size_e   size;
        logic        load_signed;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// File: regfile.sv
module regfile import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  wb_t         wb_i,
    output logic [31:0] dbg_x10_o
);

    logic [31:0] regs_q [32];

    // x0 reads zero, a register being written reads its new value
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wb_i.valid && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return regs_q[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);
    assign dbg_x10_o  = regs_q[10];

    always_ff @(posedge clk_in or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= 32'd0;
            end
        end else if (wb_i.valid && wb_i.rd != 5'd0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

// File: fetch_stage.sv
module fetch_stage import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic        rdy_i,
    input  logic        hold_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    output logic        inst_req_o,
    output logic [31:0] inst_addr_o,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_data_i,
    output if_id_t      if_id_o
);

    logic [31:0] pc_q;
    if_id_t      if_id_q;

    // one fetch at a time, only while the buffer is empty
    assign inst_req_o  = !if_id_q.valid;
    assign inst_addr_o = pc_q;
    assign if_id_o     = if_id_q;

    always_ff @(posedge clk_in or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= RESET_PC;
            if_id_q <= '0;
        end else if (rdy_i) begin
            if (redirect_valid_i) begin
                // wrong-path instruction is dropped
                pc_q          <= redirect_pc_i;
                if_id_q.valid <= 1'b0;
            end else if (inst_valid_i) begin
                if_id_q <= '{valid: 1'b1, pc: pc_q, inst: inst_data_i};
                pc_q    <= pc_q + 32'd4;
            end else if (!hold_i) begin
                // decode took it
                if_id_q.valid <= 1'b0;
            end
        end
    end

    // the flushed decode register means execute sees a bubble next
    assert property (@(posedge clk_in) disable iff (!arst_n_i)
        (redirect_valid_i && rdy_i) |=> !redirect_valid_i);

endmodule

// File: decode_stage.sv
module decode_stage import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic        rdy_i,
    input  if_id_t      if_id_i,
    input  logic        flush_i,
    input  logic        ex_busy_i,
    input  logic [4:0]  ex_load_rd_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    output logic        hold_o,
    output id_ex_t      id_ex_o
);

    logic [31:0] inst;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        use_rs1;
    logic        use_rs2;
    logic        load_use;
    id_ex_t      dec;
    id_ex_t      id_ex_q;

    assign inst   = if_id_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    always_comb begin
        dec       = '0;
        dec.valid = if_id_i.valid;
        dec.kind  = KIND_NOP;
        dec.alu_op = ALU_ADD;
        dec.op_a  = rs1_data_i;
        dec.op_b  = imm_i;
        dec.sdata = rs2_data_i;
        dec.pc    = if_id_i.pc;
        dec.rd    = inst[11:7];
        dec.size  = MEM_WORD;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            OP_LUI: begin
                dec.kind   = KIND_LUI;
                dec.alu_op = ALU_PASS_B;
                dec.op_b   = imm_u;
            end
            OP_JAL: begin
                // link value comes out of the adder as pc + 4
                dec.kind  = KIND_JAL;
                dec.op_a  = if_id_i.pc;
                dec.op_b  = 32'd4;
                dec.sdata = imm_j;
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) dec.kind = KIND_BEQ;
                if (funct3 == 3'b001) dec.kind = KIND_BNE;
                dec.op_b  = rs2_data_i;
                dec.sdata = imm_b;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OP_LOAD: begin
                if (funct3 inside {3'b000, 3'b100, 3'b010}) dec.kind = KIND_LOAD;
                dec.size        = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
                dec.load_signed = !funct3[2];
                use_rs1         = 1'b1;
            end
            OP_STORE: begin
                if (funct3 inside {3'b000, 3'b010}) dec.kind = KIND_STORE;
                dec.size = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
                dec.op_b = imm_s;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OP_IMM: begin
                use_rs1 = 1'b1;
                if (funct3 == 3'b000) begin
                    dec.kind = KIND_ALU;
                end else if (funct3 == 3'b001 && funct7 == 7'h00) begin
                    dec.kind   = KIND_ALU;
                    dec.alu_op = ALU_SLL;
                end else if (funct3 == 3'b101 && funct7 == 7'h00) begin
                    dec.kind   = KIND_ALU;
                    dec.alu_op = ALU_SRL;
                end
            end
            OP_REG: begin
                dec.kind = KIND_ALU;
                dec.op_b = rs2_data_i;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: dec.alu_op = ALU_AND;
                    {7'h00, 3'b110}: dec.alu_op = ALU_OR;
                    {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
                    default:         dec.kind   = KIND_NOP;
                endcase
            end
            default: ;
        endcase
        dec.rd_we = dec.rd != 5'd0 &&
                    dec.kind inside {KIND_ALU, KIND_LUI, KIND_JAL, KIND_LOAD};
    end

    // source register waits on a load still sitting in execute
    assign load_use = if_id_i.valid && ex_load_rd_i != 5'd0 &&
                      ((use_rs1 && rs1_addr_o == ex_load_rd_i) ||
                       (use_rs2 && rs2_addr_o == ex_load_rd_i));
    assign hold_o   = if_id_i.valid && (ex_busy_i || load_use);
    assign id_ex_o  = id_ex_q;

    always_ff @(posedge clk_in or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (rdy_i) begin
            if (flush_i) begin
                id_ex_q.valid <= 1'b0;
            end else if (!ex_busy_i) begin
                id_ex_q       <= dec;
                id_ex_q.valid <= dec.valid && !load_use;
            end
        end
    end

    // a held instruction stays in the fetch register for the next try
    assert property (@(posedge clk_in) disable iff (!arst_n_i)
        (hold_o && rdy_i) |=> (if_id_i.valid && $stable(if_id_i)));

endmodule

// File: execute_stage.sv
module execute_stage import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic        rdy_i,
    input  id_ex_t      id_ex_i,
    output logic        busy_o,
    output logic [4:0]  load_rd_o,
    output logic        redirect_valid_o,
    output logic [31:0] redirect_pc_o,
    output mem_req_t    data_req_o,
    input  logic        data_done_i,
    input  logic [31:0] data_rdata_i,
    output wb_t         wb_o
);

    logic [31:0] alu_res;
    logic [31:0] load_val;
    logic        is_load;
    logic        is_mem;
    logic        taken;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = id_ex_i.op_a + id_ex_i.op_b;
            ALU_SUB:    alu_res = id_ex_i.op_a - id_ex_i.op_b;
            ALU_AND:    alu_res = id_ex_i.op_a & id_ex_i.op_b;
            ALU_OR:     alu_res = id_ex_i.op_a | id_ex_i.op_b;
            ALU_XOR:    alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            ALU_SLT:    alu_res = {31'd0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            ALU_SLL:    alu_res = id_ex_i.op_a << id_ex_i.op_b[4:0];
            ALU_SRL:    alu_res = id_ex_i.op_a >> id_ex_i.op_b[4:0];
            default:    alu_res = id_ex_i.op_b;
        endcase
    end

    // branches compare the two register operands directly
    assign taken = id_ex_i.valid &&
                   (id_ex_i.kind == KIND_JAL ||
                    (id_ex_i.kind == KIND_BEQ && id_ex_i.op_a == id_ex_i.op_b) ||
                    (id_ex_i.kind == KIND_BNE && id_ex_i.op_a != id_ex_i.op_b));
    assign redirect_valid_o = taken;
    assign redirect_pc_o    = id_ex_i.pc + id_ex_i.sdata;

    assign is_load = id_ex_i.valid && id_ex_i.kind == KIND_LOAD;
    assign is_mem  = is_load || (id_ex_i.valid && id_ex_i.kind == KIND_STORE);

    // request stays up until the controller reports done
    assign data_req_o.valid = is_mem;
    assign data_req_o.write = id_ex_i.kind == KIND_STORE;
    assign data_req_o.size  = id_ex_i.size;
    assign data_req_o.addr  = alu_res;
    assign data_req_o.wdata = id_ex_i.sdata;

    assign busy_o    = is_mem && !data_done_i;
    assign load_rd_o = (is_load && id_ex_i.rd_we) ? id_ex_i.rd : 5'd0;

    always_comb begin
        if (id_ex_i.size == MEM_WORD) begin
            load_val = data_rdata_i;
        end else if (id_ex_i.load_signed) begin
            load_val = {{24{data_rdata_i[7]}}, data_rdata_i[7:0]};
        end else begin
            load_val = {24'd0, data_rdata_i[7:0]};
        end
    end

    assign wb_o.valid = rdy_i && id_ex_i.valid && id_ex_i.rd_we && (!is_load || data_done_i);
    assign wb_o.rd    = id_ex_i.rd;
    assign wb_o.data  = is_load ? load_val : alu_res;

    // decode holds its register, so the access cannot change midway
    assert property (@(posedge clk_in) disable iff (!arst_n_i)
        busy_o |=> $stable(data_req_o));

endmodule

// File: mem_control.sv
module mem_control import cpu_pkg::*; (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic        rdy_i,
    input  logic        flush_i,
    input  logic        inst_req_i,
    input  logic [31:0] inst_addr_i,
    output logic        inst_valid_o,
    output logic [31:0] inst_data_o,
    input  mem_req_t    data_req_i,
    output logic        data_done_o,
    output logic [31:0] data_rdata_o,
    input  logic [7:0]  mem_din_i,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o
);

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_INST_RD,
        MC_DATA_RD,
        MC_DATA_WR
    } mc_state_e;

    mc_state_e   state_q;
    logic [2:0]  cnt_q;
    logic        word_q;
    logic [31:0] base_q;
    logic [31:0] shift_q;
    logic        io_store;
    logic        req_word;
    logic        start_data;
    logic        start_inst;
    logic        last_rd;
    logic        last_wr;
    logic [31:0] word_in;
    logic [31:0] a_now;
    logic [7:0]  dout_now;
    logic [31:0] a_hold_q;
    logic [7:0]  dout_hold_q;

    // I/O stores are one byte whatever the width
    assign io_store   = data_req_i.write && data_req_i.addr[31:4] == IO_BASE[31:4];
    assign req_word   = data_req_i.size == MEM_WORD && !io_store;
    // data wins over a fetch that has not started
    assign start_data = state_q == MC_IDLE && data_req_i.valid;
    assign start_inst = state_q == MC_IDLE && !data_req_i.valid && inst_req_i && !flush_i;

    // the first byte goes out from idle, so count 1 is the second address
    assign last_rd = cnt_q == (word_q ? 3'd4 : 3'd1);
    assign last_wr = cnt_q == 3'd3;

    // little-endian assembly, newest byte on top
    assign word_in = {mem_din_i, shift_q[31:8]};

    assign a_now    = (state_q != MC_IDLE) ? base_q + {29'd0, cnt_q} :
                      data_req_i.valid ? data_req_i.addr : inst_addr_i;
    assign dout_now = (state_q == MC_IDLE) ? data_req_i.wdata[7:0] : shift_q[7:0];

    // a stalled cycle repeats the last bus cycle so the next byte matches the count
    assign mem_a_o    = rdy_i ? a_now : a_hold_q;
    assign mem_dout_o = rdy_i ? dout_now : dout_hold_q;
    assign mem_wr_o   = rdy_i && ((start_data && data_req_i.write) || state_q == MC_DATA_WR);

    assign inst_valid_o = rdy_i && state_q == MC_INST_RD && last_rd && !flush_i;
    assign inst_data_o  = word_in;

    assign data_done_o  = rdy_i && ((start_data && data_req_i.write && !req_word) ||
                                    (state_q == MC_DATA_RD && last_rd) ||
                                    (state_q == MC_DATA_WR && last_wr));
    assign data_rdata_o = word_q ? word_in : {24'd0, mem_din_i};

    always_ff @(posedge clk_in or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= MC_IDLE;
            cnt_q       <= 3'd0;
            word_q      <= 1'b0;
            a_hold_q    <= '0;
            dout_hold_q <= '0;
        end else if (rdy_i) begin
            a_hold_q    <= a_now;
            dout_hold_q <= dout_now;
            cnt_q       <= cnt_q + 3'd1;
            case (state_q)
                MC_IDLE: begin
                    cnt_q <= 3'd1;
                    if (start_data) begin
                        word_q <= req_word;
                        if (!data_req_i.write) begin
                            state_q <= MC_DATA_RD;
                        end else if (req_word) begin
                            state_q <= MC_DATA_WR;
                        end
                    end else if (start_inst) begin
                        word_q  <= 1'b1;
                        state_q <= MC_INST_RD;
                    end
                end
                // a redirect abandons the fetch
                MC_INST_RD: if (flush_i || last_rd) state_q <= MC_IDLE;
                MC_DATA_RD: if (last_rd) state_q <= MC_IDLE;
                default:    if (last_wr) state_q <= MC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_i) begin
            if (state_q == MC_IDLE) begin
                base_q  <= start_data ? data_req_i.addr : inst_addr_i;
                shift_q <= data_req_i.wdata >> 8;
            end else if (state_q == MC_DATA_WR) begin
                shift_q <= shift_q >> 8;
            end else begin
                shift_q <= word_in;
            end
        end
    end

    // bus writes only for a store that execute still requests
    assert property (@(posedge clk_in) disable iff (!arst_n_i)
        mem_wr_o |-> (data_req_i.valid && data_req_i.write));

endmodule

// File: cpu.sv
module cpu import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk_in,
    input  logic        arst_n_i,
    input  logic        rdy_i,
    input  logic [7:0]  mem_din_i,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o,
    output logic [31:0] dbgreg_dout_o
);

    // fetch <-> memory controller
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_valid;
    logic [31:0] inst_data;

    // pipeline registers and control
    if_id_t      if_id;
    id_ex_t      id_ex;
    logic        dec_hold;
    logic        ex_busy;
    logic [4:0]  ex_load_rd;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // register file
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    wb_t         wb;

    // execute <-> memory controller
    mem_req_t    data_req;
    logic        data_done;
    logic [31:0] data_rdata;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_in          (clk_in),
        .arst_n_i        (arst_n_i),
        .rdy_i           (rdy_i),
        .hold_i          (dec_hold),
        .redirect_valid_i(redirect_valid),
        .redirect_pc_i   (redirect_pc),
        .inst_req_o      (inst_req),
        .inst_addr_o     (inst_addr),
        .inst_valid_i    (inst_valid),
        .inst_data_i     (inst_data),
        .if_id_o         (if_id)
    );

    decode_stage u_decode (
        .clk_in      (clk_in),
        .arst_n_i    (arst_n_i),
        .rdy_i       (rdy_i),
        .if_id_i     (if_id),
        .flush_i     (redirect_valid),
        .ex_busy_i   (ex_busy),
        .ex_load_rd_i(ex_load_rd),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .hold_o      (dec_hold),
        .id_ex_o     (id_ex)
    );

    regfile u_regfile (
        .clk_in    (clk_in),
        .arst_n_i  (arst_n_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wb_i      (wb),
        .dbg_x10_o (dbgreg_dout_o)
    );

    execute_stage u_execute (
        .clk_in          (clk_in),
        .arst_n_i        (arst_n_i),
        .rdy_i           (rdy_i),
        .id_ex_i         (id_ex),
        .busy_o          (ex_busy),
        .load_rd_o       (ex_load_rd),
        .redirect_valid_o(redirect_valid),
        .redirect_pc_o   (redirect_pc),
        .data_req_o      (data_req),
        .data_done_i     (data_done),
        .data_rdata_i    (data_rdata),
        .wb_o            (wb)
    );

    mem_control u_mem_control (
        .clk_in      (clk_in),
        .arst_n_i    (arst_n_i),
        .rdy_i       (rdy_i),
        .flush_i     (redirect_valid),
        .inst_req_i  (inst_req),
        .inst_addr_i (inst_addr),
        .inst_valid_o(inst_valid),
        .inst_data_o (inst_data),
        .data_req_i  (data_req),
        .data_done_o (data_done),
        .data_rdata_o(data_rdata),
        .mem_din_i   (mem_din_i),
        .mem_dout_o  (mem_dout_o),
        .mem_a_o     (mem_a_o),
        .mem_wr_o    (mem_wr_o)
    );

endmodule

// File: tb_cpu.sv
module tb_cpu;

    localparam int NUM_TESTS = 7;
    localparam int MAX_WORDS = 32;
    localparam int RAM_BYTES = 131072;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 4000;
    localparam logic [31:0] OUT_ADDR = 32'h0003_0000;
    localparam logic [31:0] STOP_ADDR = 32'h0003_0004;
    localparam logic [31:0] OPC_IMM = 32'h13;
    localparam logic [31:0] OPC_LOAD = 32'h03;

    logic        clk_in;
    logic        arst_n_i;
    logic        rdy_i;
    logic [7:0]  mem_din_i;
    logic [7:0]  mem_dout_o;
    logic [31:0] mem_a_o;
    logic        mem_wr_o;
    logic [31:0] dbgreg_dout_o;

    // RAM model and output port capture
    logic [7:0]  ram [RAM_BYTES];
    logic [7:0]  out_q [$];
    logic        stop_seen;
    logic [16:0] ram_addr;
    logic [7:0]  rd_byte;

    // rdy_i pause source
    logic        pause_en;
    logic [15:0] lfsr = 16'd63;
    logic        low_a;
    logic        low_b;

    // program table
    logic [31:0] prog_words [NUM_TESTS][MAX_WORDS];
    int          prog_len [NUM_TESTS];
    logic [31:0] exp_x10 [NUM_TESTS];
    string       exp_out [NUM_TESTS];
    logic        with_pause [NUM_TESTS];

    int num_checks;
    int num_errors;

    cpu #(
        .RESET_PC(32'h0)
    ) dut (
        .clk_in       (clk_in),
        .arst_n_i     (arst_n_i),
        .rdy_i        (rdy_i),
        .mem_din_i    (mem_din_i),
        .mem_dout_o   (mem_dout_o),
        .mem_a_o      (mem_a_o),
        .mem_wr_o     (mem_wr_o),
        .dbgreg_dout_o(dbgreg_dout_o)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // byte comes back one cycle after its address
    always @(posedge clk_in) begin
        ram_addr = mem_a_o[16:0];
        if (mem_wr_o) begin
            if (mem_a_o == OUT_ADDR) begin
                if (mem_dout_o != 8'h00) begin
                    out_q.push_back(mem_dout_o);
                end
            end else if (mem_a_o == STOP_ADDR) begin
                stop_seen = 1'b1;
            end else if (mem_a_o < RAM_BYTES) begin
                ram[ram_addr] = mem_dout_o;
            end
        end
        rd_byte = ram[ram_addr];
        #1;
        mem_din_i = rd_byte;
    end

    // two lfsr bits per cycle, low when both are set
    always @(posedge clk_in) begin
        #1;
        if (pause_en) begin
            low_a = lfsr[0];
            lfsr = lfsr_next(lfsr);
            low_b = lfsr[0];
            lfsr = lfsr_next(lfsr);
            rdy_i = !(low_a && low_b);
        end else begin
            rdy_i = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("ERROR: watchdog expired before the program reached its stop write");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rtype(input logic [31:0] f7, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3,
                                          input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [31:0] imm, input logic [31:0] rs1,
                                          input logic [31:0] f3, input logic [31:0] rd,
                                          input logic [31:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] stype(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] lui_word(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic append_word(input int t, input logic [31:0] w);
        prog_words[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    // lui x5, 0x30 then sw x0, 4(x5)
    task automatic append_stop(input int t);
        append_word(t, lui_word(32'h30, 5));
        append_word(t, stype(4, 0, 5, 2));
    endtask

    task automatic arith_prog(input int t);
        append_word(t, lui_word(32'h12345, 7));
        append_word(t, itype(12, 0, 0, 1, OPC_IMM));
        append_word(t, itype(-5, 1, 0, 2, OPC_IMM));
        append_word(t, rtype(0, 2, 1, 0, 3));
        append_word(t, rtype(32, 1, 2, 0, 4));
        append_word(t, rtype(0, 7, 4, 7, 6));
        append_word(t, rtype(0, 3, 6, 6, 6));
        append_word(t, rtype(0, 4, 6, 4, 8));
        append_word(t, rtype(0, 1, 4, 2, 9));
        append_word(t, itype(4, 9, 1, 9, OPC_IMM));
        append_word(t, itype(4, 8, 5, 8, OPC_IMM));
        append_word(t, rtype(0, 9, 8, 0, 10));
        append_stop(t);
        // (0x12345013 ^ -5) >> 4, plus (-5 < 12) << 4
        exp_x10[t] = 32'h0EDC_BB0E;
        exp_out[t] = "";
    endtask

    task automatic branch_prog(input int t);
        append_word(t, itype(0, 0, 0, 10, OPC_IMM));
        append_word(t, itype(1, 0, 0, 1, OPC_IMM));
        append_word(t, itype(11, 0, 0, 2, OPC_IMM));
        // loop body at 0x0c
        append_word(t, rtype(0, 1, 10, 0, 10));
        append_word(t, itype(1, 1, 0, 1, OPC_IMM));
        append_word(t, btype(-8, 2, 1, 1));
        append_word(t, btype(8, 10, 10, 0));
        append_word(t, itype(2047, 0, 0, 10, OPC_IMM));
        append_word(t, jal_word(8, 3));
        append_word(t, itype(1, 0, 0, 10, OPC_IMM));
        append_word(t, rtype(0, 3, 10, 0, 10));
        append_stop(t);
        // 55 plus the link value 0x24
        exp_x10[t] = 32'd91;
        exp_out[t] = "";
    endtask

    task automatic memory_prog(input int t);
        append_word(t, lui_word(1, 1));
        append_word(t, lui_word(32'h89ABC, 2));
        append_word(t, itype(245, 2, 0, 2, OPC_IMM));
        append_word(t, stype(0, 2, 1, 2));
        append_word(t, itype(0, 1, 0, 3, OPC_LOAD));
        append_word(t, itype(3, 1, 4, 4, OPC_LOAD));
        append_word(t, rtype(0, 4, 3, 0, 6));
        append_word(t, itype(0, 1, 2, 7, OPC_LOAD));
        append_word(t, rtype(0, 6, 7, 4, 10));
        append_word(t, stype(1, 10, 1, 0));
        append_word(t, itype(0, 1, 2, 8, OPC_LOAD));
        append_word(t, rtype(32, 10, 8, 0, 10));
        append_stop(t);
        // 0x89ab8bf5 - 0x89abc08b
        exp_x10[t] = 32'hFFFF_CB6A;
        exp_out[t] = "";
    endtask

    task automatic output_prog(input int t);
        append_word(t, lui_word(32'h30, 5));
        append_word(t, itype(79, 0, 0, 1, OPC_IMM));
        append_word(t, stype(0, 1, 5, 0));
        append_word(t, itype(75, 0, 0, 1, OPC_IMM));
        append_word(t, stype(0, 1, 5, 0));
        append_word(t, itype(10, 0, 0, 1, OPC_IMM));
        append_word(t, stype(0, 1, 5, 2));
        append_word(t, stype(0, 0, 5, 0));
        append_word(t, itype(3, 0, 0, 10, OPC_IMM));
        append_stop(t);
        exp_x10[t] = 32'd3;
        exp_out[t] = "OK\n";
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            with_pause[t] = 1'b0;
        end
        arith_prog(0);
        branch_prog(1);
        memory_prog(2);
        output_prog(3);
        // reruns with rdy_i pauses
        branch_prog(4);
        memory_prog(5);
        output_prog(6);
        with_pause[4] = 1'b1;
        with_pause[5] = 1'b1;
        with_pause[6] = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        num_checks++;
        if (got !== expected) begin
            num_errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic run_entry(input int t);
        string expected_text;
        pause_en = 1'b0;
        #1;
        arst_n_i = 1'b0;
        repeat (10) @(posedge clk_in);
        pause_en = with_pause[t];
        #1;
        for (int a = 0; a < RAM_BYTES; a++) begin
            ram[17'(a)] = 8'h00;
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            for (int k = 0; k < 4; k++) begin
                ram[17'(4 * i + k)] = prog_words[t][i][8 * k +: 8];
            end
        end
        out_q.delete();
        stop_seen = 1'b0;
        arst_n_i = 1'b1;
        while (!stop_seen) begin
            @(posedge clk_in);
        end
        // let trailing writes show up before comparing
        repeat (20) @(posedge clk_in);
        expected_text = exp_out[t];
        check_value($sformatf("dbgreg_dout_o[%0d]", t), dbgreg_dout_o, exp_x10[t]);
        check_value($sformatf("out_len[%0d]", t), out_q.size(), expected_text.len());
        for (int i = 0; i < out_q.size() && i < expected_text.len(); i++) begin
            check_value($sformatf("out_byte[%0d][%0d]", t, i), 32'(out_q[i]),
                        32'(expected_text[i]));
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        rdy_i = 1'b1;
        mem_din_i = 8'h00;
        pause_en = 1'b0;
        stop_seen = 1'b0;
        num_checks = 0;
        num_errors = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
cpu_pkg.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_control.sv
cpu.sv
tb_cpu.sv

// File: Makefile
.PHONY: run clean

obj_dir/Vtb_cpu: tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -j 0 --top-module tb_cpu -f tb.f

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
	cat sim.log
	! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
